// File: test/layer2_vectors.txt
# Tags C addr data, S start, W four quads of one kernel with taps 0 to 15 left to right,
# P sixteen pixels, E expected out_data with lane 3 first, D frame end, H hold credits. Hex.
# First frame runs the reset configuration with one window.
W 1111 1111 1111 1111
W FFFF FFFF FFFF FFFF
W 2000 0000 0000 0000
W F1F1 F1F1 F1F1 F1F1
P 0001 0002 0003 0004 0005 0006 0007 0008 0000 0000 0000 0000 0000 0000 0000 0000
E 04020024
S
D
# Second frame uses shift 2 without ReLU, a window count of 0 runs one window.
C 0 03
C 0 00
C 1 02
C 2 00
W 7777 7777 7777 7777
W 8888 8888 8888 8888
W 1111 1111 1111 1111
W FFFF FFFF FFFF FFFF
P 012C FFCE 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
E C13E807F
S
# Writes and a start while busy are dropped.
C 1 00
C 2 01
C 0 05
S
D
# Third frame has three windows under downstream back-pressure.
C 0 03
W 1111 1111 1111 1111
W 4000 0000 0000 0000
W FFFF FFFF FFFF FFFF
W 0000 0000 0000 000C
P 000A 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0014
P FFFB 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 FFF9
P 03E8 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 03E8
E ECF10A0E
E 0703FBFD
E 80807F7F
H 190
S
D

// File: list.f
verilog/layer2_data_pkg.sv
verilog/layer2_ctrl_pkg.sv
verilog/layer2_cfg_regs.sv
verilog/layer2_ctrl.sv
verilog/weight_store.sv
verilog/mac_array.sv
verilog/credit_tx.sv
verilog/layer2_top.sv
test/layer2_assert.sv
test/layer2_tb.sv

// File: Bender.yml
package:
  name: layer2

sources:
  - verilog/layer2_data_pkg.sv
  - verilog/layer2_ctrl_pkg.sv
  - verilog/layer2_cfg_regs.sv
  - verilog/layer2_ctrl.sv
  - verilog/weight_store.sv
  - verilog/mac_array.sv
  - verilog/credit_tx.sv
  - verilog/layer2_top.sv
  - target: test
    files:
      - test/layer2_assert.sv
      - test/layer2_tb.sv

// File: test/layer2_tb.sv
`timescale 1ns/100ps

module layer2_tb
    import layer2_data_pkg::*;
    import layer2_ctrl_pkg::*;
();

    localparam string       VEC_FILE = "test/layer2_vectors.txt";
    localparam int unsigned SEED     = 32'h6550_bbc0;

    logic                         clk;
    logic                         arst_n;
    logic                         start;
    logic                         in_valid;
    logic [PIXEL_W-1:0]           in_word;
    logic                         out_credit;
    logic                         cfg_we;
    logic [1:0]                   cfg_addr;
    logic [7:0]                   cfg_wdata;
    logic                         in_credit;
    logic                         out_valid;
    logic [NUM_KERNELS*RES_W-1:0] out_data;
    logic                         frame_done;

    // Parsed vectors and traffic bookkeeping.
    byte                tag_q[$];
    logic [31:0]        val_q[$];
    logic [PIXEL_W-1:0] up_q[$];
    logic [31:0]        exp_q[$];
    int                 ret_q[$];
    int                 cycle           = 0;
    int                 cycle_limit     = 0;
    int                 word_count      = 0;
    int                 done_count      = 0;
    int                 accepted_starts = 0;
    int                 outstanding     = 0;
    int                 hold_until      = 0;

    layer2_top dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .out_credit (out_credit),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .frame_done (frame_done)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // Failure reporting and vector parsing.
    // ------------------------------------------------------------
    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_now($sformatf("CHECK FAILED at time %0t: %s expected %h, got %h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic int values_per_tag(input byte tag);
        case (tag)
            "C": return 2;
            "W": return NUM_TAPS / 4;
            "P": return NUM_TAPS;
            "E", "H": return 1;
            "S", "D": return 0;
            default: return -1;
        endcase
    endfunction

    task automatic read_vectors();
        int                fd;
        int                r;
        int                n;
        byte               tag;
        logic [31:0]       v;
        logic [8*256-1:0]  rest;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) fail_now("Could not open the vectors file.");
        while (!$feof(fd)) begin
            r = $fscanf(fd, " %c", tag);
            if (r != 1) break;
            if (tag == "#") begin
                r = $fgets(rest, fd);
            end else begin
                n = values_per_tag(tag);
                if (n < 0) fail_now($sformatf("Unknown tag %c in the vectors file.", tag));
                tag_q.push_back(tag);
                for (int i = 0; i < n; i++) begin
                    r = $fscanf(fd, "%h", v);
                    if (r != 1) fail_now("A line of the vectors file is too short.");
                    val_q.push_back(v);
                end
                if (tag == "W" || tag == "P" || tag == "E") word_count += n;
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------
    // Stimulus helpers, all driven 2 ns after the edge.
    // ------------------------------------------------------------
    task automatic apply_config(input logic [1:0] addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #2;
        cfg_we = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic wait_frame_end();
        while (done_count < accepted_starts || exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    // Upstream and downstream partners. Outputs are sampled 1 ns after the
    // edge and the replies applied at 2 ns.
    initial begin : traffic
        logic               up_pending;
        int                 up_delay;
        logic               nxt_valid;
        logic [PIXEL_W-1:0] nxt_word;
        logic               nxt_credit;
        logic [31:0]        exp_word;
        void'($urandom(SEED));
        up_pending = 1'b0;
        up_delay   = 0;
        forever begin
            @(posedge clk);
            #1;
            cycle++;
            if (cycle > cycle_limit) begin
                fail_now($sformatf("Timeout, the run went past %0d cycles.", cycle_limit));
            end
            if (dut0.layer2_assert0.fail_count != 0) fail_now("A protocol assertion failed.");
            nxt_valid  = 1'b0;
            nxt_word   = in_word;
            nxt_credit = 1'b0;
            if (up_pending) begin
                if (up_delay == 0) begin
                    nxt_valid  = 1'b1;
                    nxt_word   = up_q.pop_front();
                    up_pending = 1'b0;
                end else begin
                    up_delay--;
                end
            end
            if (in_credit) begin
                if (up_pending) fail_now("in_credit came while a credit was unanswered.");
                if (up_q.size() == 0) fail_now("in_credit came with no input word left.");
                up_pending = 1'b1;
                up_delay   = $urandom_range(3, 0);
            end
            if (out_valid) begin
                if (exp_q.size() == 0) fail_now("out_valid came with no result word expected.");
                exp_word = exp_q.pop_front();
                check_value("out_data", exp_word, out_data);
                outstanding++;
                check_value("outstanding within OUT_CREDITS", 1, outstanding <= OUT_CREDITS);
                ret_q.push_back(cycle + 1 + int'($urandom_range(6, 0)));
            end
            if (ret_q.size() != 0 && ret_q[0] <= cycle && cycle >= hold_until) begin
                nxt_credit = 1'b1;
                void'(ret_q.pop_front());
                outstanding--;
            end
            if (frame_done) begin
                done_count++;
                // Only the word in the output register may still be on its way.
                check_value("results pending at frame_done", 1, exp_q.size() <= 1);
            end
            #1;
            in_valid   = nxt_valid;
            in_word    = nxt_word;
            out_credit = nxt_credit;
        end
    end

    // ------------------------------------------------------------
    // Main sequence.
    // ------------------------------------------------------------
    initial begin : main_seq
        byte         tag;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] v;
        logic        frame_open;
        clk        = 1'b0;
        arst_n     = 1'b0;
        start      = 1'b0;
        in_valid   = 1'b0;
        in_word    = '0;
        out_credit = 1'b0;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        frame_open = 1'b0;
        read_vectors();
        cycle_limit = 64 * word_count + 200;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        while (tag_q.size() != 0) begin
            tag = tag_q.pop_front();
            case (tag)
                "C": begin
                    a = val_q.pop_front();
                    d = val_q.pop_front();
                    apply_config(a[1:0], d[7:0]);
                end
                "W", "P": begin
                    for (int i = 0; i < values_per_tag(tag); i++) begin
                        v = val_q.pop_front();
                        up_q.push_back(v[PIXEL_W-1:0]);
                    end
                end
                "E": exp_q.push_back(val_q.pop_front());
                "H": hold_until = cycle + int'(val_q.pop_front());
                "S": begin
                    // A start inside a running frame must be dropped.
                    if (!frame_open) begin
                        accepted_starts++;
                        frame_open = 1'b1;
                    end
                    pulse_start();
                end
                "D": begin
                    wait_frame_end();
                    check_value("frame_done pulses", accepted_starts, done_count);
                    check_value("input words left", 0, up_q.size());
                    frame_open = 1'b0;
                end
                default: fail_now("Unexpected tag in the parsed vectors.");
            endcase
        end
        repeat (20) @(posedge clk);
        #2;
        check_value("frame_done pulses at end", accepted_starts, done_count);
        check_value("result words missing", 0, exp_q.size());
        check_value("input words left at end", 0, up_q.size());
        if (dut0.layer2_assert0.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_now("A protocol assertion failed.");
        end
    end

endmodule

// File: test/layer2_assert.sv
`timescale 1ns/100ps

module layer2_assert
    import layer2_ctrl_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic in_credit,
    input logic in_valid,
    input logic out_valid,
    input logic out_credit
);

    logic       credit_open;
    logic [2:0] in_flight;
    int         fail_count = 0;

    // Tracks the upstream credit and the words not yet returned downstream.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_open <= 1'b0;
            in_flight   <= 3'd0;
        end else begin
            if (in_credit) begin
                credit_open <= 1'b1;
            end else if (in_valid) begin
                credit_open <= 1'b0;
            end
            in_flight <= in_flight + 3'(out_valid) - 3'(out_credit);
        end
    end

    credit_one_at_a_time: assert property (
        @(posedge clk) disable iff (!arst_n) in_credit |-> !credit_open
    ) else begin
        $error("in_credit issued while the previous credit is unanswered");
        fail_count++;
    end

    send_within_credit: assert property (
        @(posedge clk) disable iff (!arst_n) out_valid |-> in_flight < 3'(OUT_CREDITS)
    ) else begin
        $error("out_valid sent without downstream credit");
        fail_count++;
    end

    quiet_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> !out_valid && !in_credit
    ) else begin
        $error("outputs active in the first cycle after reset");
        fail_count++;
    end

endmodule

bind layer2_top layer2_assert layer2_assert0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_credit  (in_credit),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .out_credit (out_credit)
);

// File: verilog/layer2_top.sv
`timescale 1ns/100ps

module layer2_top
    import layer2_data_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         start,
    input  logic                         in_valid,
    input  logic [PIXEL_W-1:0]           in_word,
    input  logic                         out_credit,
    input  logic                         cfg_we,
    input  logic [1:0]                   cfg_addr,
    input  logic [7:0]                   cfg_wdata,
    output logic                         in_credit,
    output logic                         out_valid,
    output logic [NUM_KERNELS*RES_W-1:0] out_data,
    output logic                         frame_done
);

    logic [7:0]                           windows;
    logic [3:0]                           shift;
    logic                                 relu_en;
    logic                                 busy;
    logic                                 ws_we;
    logic [1:0]                           ws_kernel;
    logic [1:0]                           ws_quad;
    logic                                 mac_clear;
    logic                                 mac_acc;
    logic [3:0]                           mac_tap;
    logic                                 mac_post;
    logic                                 res_load;
    logic                                 res_free;
    logic [NUM_KERNELS-1:0][WEIGHT_W-1:0] weights;
    logic [NUM_KERNELS*RES_W-1:0]         result;

    // ------------------------------------------------------------
    // Configuration and sequencing.
    // ------------------------------------------------------------
    layer2_cfg_regs cfg0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .busy      (busy),
        .windows   (windows),
        .shift     (shift),
        .relu_en   (relu_en)
    );

    layer2_ctrl ctrl0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .in_valid   (in_valid),
        .windows    (windows),
        .res_free   (res_free),
        .in_credit  (in_credit),
        .busy       (busy),
        .ws_we      (ws_we),
        .ws_kernel  (ws_kernel),
        .ws_quad    (ws_quad),
        .mac_clear  (mac_clear),
        .mac_acc    (mac_acc),
        .mac_tap    (mac_tap),
        .mac_post   (mac_post),
        .res_load   (res_load),
        .frame_done (frame_done)
    );

    // ------------------------------------------------------------
    // Datapath.
    // ------------------------------------------------------------
    weight_store ws0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (ws_we),
        .kernel  (ws_kernel),
        .quad    (ws_quad),
        .word    (in_word),
        .tap     (mac_tap),
        .weights (weights)
    );

    mac_array mac0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .clear   (mac_clear),
        .acc     (mac_acc),
        .post    (mac_post),
        .word    (in_word),
        .weights (weights),
        .shift   (shift),
        .relu_en (relu_en),
        .result  (result)
    );

    credit_tx tx0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .load       (res_load),
        .result     (result),
        .out_credit (out_credit),
        .res_free   (res_free),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

// File: verilog/credit_tx.sv
`timescale 1ns/100ps

module credit_tx
    import layer2_data_pkg::*;
    import layer2_ctrl_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         load,
    input  logic [NUM_KERNELS*RES_W-1:0] result,
    input  logic                         out_credit,
    output logic                         res_free,
    output logic                         out_valid,
    output logic [NUM_KERNELS*RES_W-1:0] out_data
);

    logic                         full;
    logic [NUM_KERNELS*RES_W-1:0] data_q;
    logic [$bits(OUT_CREDITS)-1:0] credits;

    assign res_free  = !full;
    assign out_valid = full && (credits != '0);
    assign out_data  = data_q;

    always_ff @(posedge clk) begin
        if (load) data_q <= result;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full    <= 1'b0;
            credits <= OUT_CREDITS;
        end else begin
            if (load) begin
                full <= 1'b1;
            end else if (out_valid) begin
                full <= 1'b0;
            end
            // Send and return in one cycle cancel out.
            case ({out_valid, out_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: if (credits != OUT_CREDITS) credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: verilog/mac_array.sv
`timescale 1ns/100ps

module mac_array
    import layer2_data_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 clear,
    input  logic                                 acc,
    input  logic                                 post,
    input  in_word_t                             word,
    input  logic [NUM_KERNELS-1:0][WEIGHT_W-1:0] weights,
    input  logic [3:0]                           shift,
    input  logic                                 relu_en,
    output logic [NUM_KERNELS*RES_W-1:0]         result
);

    logic signed [ACC_W-1:0] acc_q   [NUM_KERNELS];
    logic signed [ACC_W-1:0] shifted [NUM_KERNELS];
    logic [RES_W-1:0]        lane    [NUM_KERNELS];

    // ------------------------------------------------------------
    // Accumulate pixel times weight in every lane.
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < NUM_KERNELS; k++) begin
                acc_q[k] <= '0;
            end
        end else if (clear) begin
            for (int k = 0; k < NUM_KERNELS; k++) begin
                acc_q[k] <= '0;
            end
        end else if (acc) begin
            for (int k = 0; k < NUM_KERNELS; k++) begin
                acc_q[k] <= acc_q[k] + $signed(word.pixel) * $signed(weights[k]);
            end
        end
    end

    // ------------------------------------------------------------
    // Shift, ReLU and saturate to the lane width.
    // ------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < NUM_KERNELS; k++) begin
            shifted[k] = acc_q[k] >>> shift;
            if (relu_en && shifted[k] < 0) shifted[k] = '0;
            // In range when the bits above the lane all match its sign.
            if (&shifted[k][ACC_W-1:RES_W-1] || ~|shifted[k][ACC_W-1:RES_W-1]) begin
                lane[k] = shifted[k][RES_W-1:0];
            end else if (shifted[k][ACC_W-1]) begin
                lane[k] = {1'b1, {(RES_W-1){1'b0}}};
            end else begin
                lane[k] = {1'b0, {(RES_W-1){1'b1}}};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (post) begin
            for (int k = 0; k < NUM_KERNELS; k++) begin
                result[RES_W*k +: RES_W] <= lane[k];
            end
        end
    end

endmodule

// File: verilog/weight_store.sv
`timescale 1ns/100ps

module weight_store
    import layer2_data_pkg::*;
(
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                we,
    input  logic [1:0]                          kernel,
    input  logic [1:0]                          quad,
    input  in_word_t                            word,
    input  logic [3:0]                          tap,
    output logic [NUM_KERNELS-1:0][WEIGHT_W-1:0] weights
);

    logic [WEIGHT_W-1:0] mem [NUM_KERNELS][NUM_TAPS];

    // A quad fills taps 4q..4q+3, top nibble first.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < NUM_KERNELS; k++) begin
                for (int t = 0; t < NUM_TAPS; t++) begin
                    mem[k][t] <= '0;
                end
            end
        end else if (we) begin
            for (int i = 0; i < 4; i++) begin
                mem[kernel][{quad, 2'(i)}] <= word.quad[3 - i];
            end
        end
    end

    // Same tap from every kernel.
    always_comb begin
        for (int k = 0; k < NUM_KERNELS; k++) begin
            weights[k] = mem[k][tap];
        end
    end

endmodule

// File: verilog/layer2_ctrl.sv
`timescale 1ns/100ps

module layer2_ctrl
    import layer2_data_pkg::*;
    import layer2_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  logic       in_valid,
    input  logic [7:0] windows,
    input  logic       res_free,
    output logic       in_credit,
    output logic       busy,
    output logic       ws_we,
    output logic [1:0] ws_kernel,
    output logic [1:0] ws_quad,
    output logic       mac_clear,
    output logic       mac_acc,
    output logic [3:0] mac_tap,
    output logic       mac_post,
    output logic       res_load,
    output logic       frame_done
);

    logic [3:0] state;
    logic [3:0] next_state;
    logic [3:0] load_cnt;
    logic [3:0] tap_cnt;
    logic [7:0] win_cnt;
    logic       last_load;
    logic       last_tap;
    logic       last_win;

    // Load counter is {kernel, quad}, so quads run fastest.
    assign ws_kernel = load_cnt[3:2];
    assign ws_quad   = load_cnt[1:0];
    assign mac_tap   = tap_cnt;
    assign busy      = (state != S_IDLE);

    assign last_load = (load_cnt == 4'(NUM_KERNELS * NUM_TAPS / 4 - 1));
    assign last_tap  = (tap_cnt == 4'(NUM_TAPS - 1));
    assign last_win  = (win_cnt == windows - 8'd1);

    // ------------------------------------------------------------
    // Next state and strobes.
    // ------------------------------------------------------------
    always_comb begin
        next_state = state;
        in_credit  = 1'b0;
        ws_we      = 1'b0;
        mac_clear  = 1'b0;
        mac_acc    = 1'b0;
        mac_post   = 1'b0;
        res_load   = 1'b0;
        frame_done = 1'b0;
        case (state)
            S_IDLE: begin
                if (start) next_state = S_LOAD_REQ;
            end
            S_LOAD_REQ: begin
                in_credit  = 1'b1;
                next_state = S_LOAD_WAIT;
            end
            S_LOAD_WAIT: begin
                if (in_valid) begin
                    ws_we      = 1'b1;
                    next_state = last_load ? S_TAP_REQ : S_LOAD_REQ;
                end
            end
            S_TAP_REQ: begin
                in_credit  = 1'b1;
                // First tap of a window starts from a clean accumulator.
                mac_clear  = (tap_cnt == 4'd0);
                next_state = S_TAP_WAIT;
            end
            S_TAP_WAIT: begin
                if (in_valid) begin
                    mac_acc    = 1'b1;
                    next_state = last_tap ? S_POST : S_TAP_REQ;
                end
            end
            S_POST: begin
                mac_post   = 1'b1;
                next_state = S_SEND;
            end
            S_SEND: begin
                if (res_free) begin
                    res_load   = 1'b1;
                    next_state = last_win ? S_DONE : S_TAP_REQ;
                end
            end
            S_DONE: begin
                frame_done = 1'b1;
                next_state = S_IDLE;
            end
            default: next_state = S_IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // State and counters.
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            load_cnt <= 4'd0;
            tap_cnt  <= 4'd0;
            win_cnt  <= 8'd0;
        end else begin
            state <= next_state;
            if (state == S_IDLE) begin
                load_cnt <= 4'd0;
                tap_cnt  <= 4'd0;
                win_cnt  <= 8'd0;
            end
            if (ws_we) load_cnt <= load_cnt + 4'd1;
            // Wraps to zero after the last tap.
            if (mac_acc) tap_cnt <= tap_cnt + 4'd1;
            if (res_load) win_cnt <= win_cnt + 8'd1;
        end
    end

endmodule

// File: verilog/layer2_cfg_regs.sv
`timescale 1ns/100ps

module layer2_cfg_regs
    import layer2_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  logic [7:0] cfg_wdata,
    input  logic       busy,
    output logic [7:0] windows,
    output logic [3:0] shift,
    output logic       relu_en
);

    logic wr_ok;

    // Frame parameters are frozen while a frame runs.
    assign wr_ok = cfg_we && !busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            windows <= WINDOWS_RESET;
            shift   <= SHIFT_RESET;
            relu_en <= RELU_RESET;
        end else if (wr_ok) begin
            case (cfg_addr)
                CFG_ADDR_WINDOWS: begin
                    // Zero windows makes no sense, run one instead.
                    windows <= (cfg_wdata == 8'd0) ? 8'd1 : cfg_wdata;
                end
                CFG_ADDR_SHIFT:   shift   <= cfg_wdata[3:0];
                CFG_ADDR_RELU:    relu_en <= cfg_wdata[0];
                default: ;
            endcase
        end
    end

endmodule

// File: verilog/layer2_ctrl_pkg.sv
package layer2_ctrl_pkg;

    // ------------------------------------------------------------
    // Sequencer state codes.
    // ------------------------------------------------------------
    localparam logic [3:0] S_IDLE      = 4'd0;
    localparam logic [3:0] S_LOAD_REQ  = 4'd1;
    localparam logic [3:0] S_LOAD_WAIT = 4'd2;
    localparam logic [3:0] S_TAP_REQ   = 4'd3;
    localparam logic [3:0] S_TAP_WAIT  = 4'd4;
    localparam logic [3:0] S_POST      = 4'd5;
    localparam logic [3:0] S_SEND      = 4'd6;
    localparam logic [3:0] S_DONE      = 4'd7;

    // ------------------------------------------------------------
    // Configuration map and reset values.
    // ------------------------------------------------------------
    localparam logic [1:0] CFG_ADDR_WINDOWS = 2'd0;
    localparam logic [1:0] CFG_ADDR_SHIFT   = 2'd1;
    localparam logic [1:0] CFG_ADDR_RELU    = 2'd2;

    localparam logic [7:0] WINDOWS_RESET = 8'd1;
    localparam logic [3:0] SHIFT_RESET   = 4'd0;
    localparam logic       RELU_RESET    = 1'b1;

    // Downstream buffer depth.
    localparam logic [1:0] OUT_CREDITS = 2'd2;

endpackage

// File: verilog/layer2_data_pkg.sv
package layer2_data_pkg;

    // ------------------------------------------------------------
    // Array geometry.
    // ------------------------------------------------------------
    localparam int NUM_KERNELS = 4;
    localparam int NUM_TAPS    = 16;

    // ------------------------------------------------------------
    // Data widths.
    // ------------------------------------------------------------
    localparam int WEIGHT_W = 4;
    localparam int PIXEL_W  = 16;
    localparam int ACC_W    = 24;
    localparam int RES_W    = 8;

    // One upstream word, read as a weight quad while loading and as a
    // pixel while accumulating.
    // quad[3] is the top nibble and belongs to the lowest tap of the quad.
    typedef union packed {
        logic [3:0][WEIGHT_W-1:0]  quad;
        logic signed [PIXEL_W-1:0] pixel;
    } in_word_t;

endpackage
